//--- all.f
src/softmax_pkg.sv
src/softmax_frontend.sv
src/reciprocal_divider.sv
src/softmax_backend.sv
src/softmax_top.sv
testbench/softmax_sva.sv
testbench/softmax_tb.sv

//--- src/reciprocal_divider.sv
/*
 * reciprocal of the exponential sum in Q5.10
 *   s0 capture, s1 divide, s2 spare, output register
 *   exponentials carried alongside every stage
 */
`timescale 1ns/10ps

module reciprocal_divider (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       exp_valid,
    input  softmax_pkg::exp_bundle_t   exp_bundle,
    output logic                       recip_valid,
    output softmax_pkg::recip_bundle_t recip_bundle
);
    import softmax_pkg::*;

    logic          valid_s0;
    logic          valid_s1;
    logic          valid_s2;
    logic [19:0]   sum_s0;      // sum never exceeds 16384
    exp_vec_t      exps_s0;
    logic [20:0]   quot_c;      // recip_dividend needs 21 bits
    recip_bundle_t bundle_s1;
    recip_bundle_t bundle_s2;

    // ========================================
    // valid shift register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s0    <= 1'b0;
            valid_s1    <= 1'b0;
            valid_s2    <= 1'b0;
            recip_valid <= 1'b0;
        end else begin
            valid_s0    <= exp_valid;
            valid_s1    <= valid_s0;
            valid_s2    <= valid_s1;
            recip_valid <= valid_s2;
        end
    end

    // 2^20 / sum, truncated toward zero
    // sum >= one_q so quotient <= one_q, fits recip_t
    assign quot_c = 21'(recip_dividend) / 21'(sum_s0);

    // ========================================
    // data stages
    // ========================================
    always_ff @(posedge clk) begin
        if (exp_valid) begin                   // s0 capture
            sum_s0  <= exp_bundle.exp_sum[19:0];
            exps_s0 <= exp_bundle.exp_values;
        end
        if (valid_s0) begin                    // s1 divide
            bundle_s1.reciprocal <= recip_t'(quot_c);
            bundle_s1.exp_values <= exps_s0;
        end
        if (valid_s1) begin
            bundle_s2 <= bundle_s1;            // s2, slot for a refinement step
        end
        if (valid_s2) begin
            recip_bundle <= bundle_s2;         // output register
        end
    end

endmodule

//--- src/softmax_backend.sv
/*
 * softmax backend
 *   exponential x reciprocal per element, rescale to Q5.10
 *   registered probabilities and strobe
 */
`timescale 1ns/10ps

module softmax_backend (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       recip_valid,
    input  softmax_pkg::recip_bundle_t recip_bundle,
    output logic                       valid_out,
    output softmax_pkg::prob_vec_t     probs_out
);
    import softmax_pkg::*;

    localparam int prod_w = $bits(exp_t) + $bits(recip_t);   // full 16x16 product

    prob_vec_t probs_c;

    // ========================================
    // scaling
    // ========================================
    // exp_i <= sum, so exp_i * floor(2^20/sum) <= 2^20
    // result after the shift stays <= one_q, no saturation
    always_comb begin : scale
        logic [prod_w-1:0] prod;
        for (int i = 0; i < vec_len; i++) begin
            prod       = prod_w'(recip_bundle.exp_values[i]) * prod_w'(recip_bundle.reciprocal);
            probs_c[i] = prod[frac_bits +: $bits(prob_t)];   // >> frac_bits, truncate
        end
    end

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            probs_out <= '0;              // zero vector out of reset
        end else begin
            valid_out <= recip_valid;
            if (recip_valid) begin
                probs_out <= probs_c;
            end
        end
    end

endmodule

//--- src/softmax_frontend.sv
/*
 * softmax frontend, three register stages
 *   max search by comparison tree, max subtraction
 *   quarter-step exponential table, sum of exponentials
 */
`timescale 1ns/10ps

module softmax_frontend (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid_in,
    input  softmax_pkg::logit_vec_t  logits_in,
    output logic                     exp_valid,
    output softmax_pkg::exp_bundle_t exp_bundle
);
    import softmax_pkg::*;

    localparam int idx_w = $clog2(exp_lut_depth);   // 6 bit table index

    // round(one_q * e^(-k/4)), everything past k = 30 rounds to zero
    localparam exp_t exp_lut [exp_lut_depth] = '{
        16'd1024, 16'd797,  16'd621,  16'd484,  16'd377,  16'd293,  16'd228,  16'd178,
        16'd139,  16'd108,  16'd84,   16'd65,   16'd51,   16'd40,   16'd31,   16'd24,
        16'd19,   16'd15,   16'd11,   16'd9,    16'd7,    16'd5,    16'd4,    16'd3,
        16'd3,    16'd2,    16'd2,    16'd1,    16'd1,    16'd1,    16'd1,    16'd0,
        16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,
        16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,
        16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,
        16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0,    16'd0
    };

    logic       valid_s1;
    logic       valid_s2;
    logit_t     max_c;       // tree output, straight from logits_in
    logit_t     max_s1;
    logit_vec_t logits_s1;
    exp_vec_t   exps_c;
    exp_vec_t   exps_s2;
    sum_t       sum_c;

    // strobe follows the data three stages deep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            exp_valid <= 1'b0;
        end else begin
            valid_s1  <= valid_in;
            valid_s2  <= valid_s1;
            exp_valid <= valid_s2;
        end
    end

    // ========================================
    // stage 1  max search
    // ========================================
    // pairwise tree, 16 -> 8 -> 4 -> 2 -> 1
    always_comb begin : max_tree
        logit_t cand [vec_len];
        for (int i = 0; i < vec_len; i++) begin
            cand[i] = logits_in[i];
        end
        for (int w = vec_len / 2; w > 0; w = w / 2) begin
            for (int i = 0; i < w; i++) begin
                cand[i] = ($signed(cand[2*i]) > $signed(cand[2*i+1])) ? cand[2*i] : cand[2*i+1];
            end
        end
        max_c = cand[0];
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            logits_s1 <= logits_in;
            max_s1    <= max_c;
        end
    end

    // ========================================
    // stage 2  subtract max, table lookup
    // ========================================
    always_comb begin : exp_lookup
        logic signed [16:0] diff;   // x - max, zero or negative
        logic        [16:0] mag;    // negated diff
        logic [idx_w-1:0]   idx;
        for (int i = 0; i < vec_len; i++) begin
            diff = {logits_s1[i][15], logits_s1[i]} - {max_s1[15], max_s1};
            mag  = 17'(-diff);
            if (mag[16:8] > 9'(exp_lut_depth - 1)) begin
                idx = idx_w'(exp_lut_depth - 1);   // clamp to table end
            end else begin
                idx = mag[8 +: idx_w];             // one entry per 256 (0.25)
            end
            exps_c[i] = exp_lut[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s1) exps_s2 <= exps_c;
    end

    // ========================================
    // stage 3  sum of exponentials
    // ========================================
    always_comb begin : exp_adder
        sum_c = '0;
        for (int i = 0; i < vec_len; i++) begin
            sum_c = sum_c + sum_t'(exps_s2[i]);   // max term adds exactly one_q
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s2) begin
            exp_bundle.exp_sum    <= sum_c;
            exp_bundle.exp_values <= exps_s2;   // exponentials ride beside the sum
        end
    end

endmodule

//--- src/softmax_pkg.sv
/*
 * shared package for the softmax pipeline
 *   sizes and Q5.10 constants
 *   element and vector types, stage-to-stage bundles
 */
package softmax_pkg;

    // ========================================
    // sizes and fixed-point constants
    // ========================================
    localparam int vec_len        = 16;               // elements per vector
    localparam int frac_bits      = 10;               // Q5.10
    localparam int one_q          = 1 << frac_bits;   // 1.0
    localparam int exp_lut_depth  = 64;               // quarter-unit steps, 0 .. -15.75
    localparam int recip_dividend = one_q * one_q;    // 1/x back in Q5.10
    localparam int pipe_latency   = 8;                // frontend 3 + divider 4 + backend 1

    // element types
    typedef logic signed [15:0] logit_t;   // signed Q5.10 input
    typedef logic        [15:0] exp_t;     // 0 .. 1.0
    typedef logic        [31:0] sum_t;     // 1024 .. 16384 in practice
    typedef logic        [15:0] recip_t;
    typedef logic        [15:0] prob_t;

    typedef logit_t [vec_len-1:0] logit_vec_t;
    typedef exp_t   [vec_len-1:0] exp_vec_t;
    typedef prob_t  [vec_len-1:0] prob_vec_t;

    // frontend -> divider
    typedef struct packed {
        sum_t     exp_sum;
        exp_vec_t exp_values;
    } exp_bundle_t;

    // divider -> backend
    typedef struct packed {
        recip_t   reciprocal;
        exp_vec_t exp_values;
    } recip_bundle_t;

endpackage

//--- src/softmax_top.sv
/*
 * softmax top level
 *   frontend -> reciprocal divider -> backend, 8 cycles end to end
 */
`timescale 1ns/10ps

module softmax_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,    // one-cycle strobe, any cycle
    input  softmax_pkg::logit_vec_t logits_in,
    output logic                    valid_out,   // no back-pressure
    output softmax_pkg::prob_vec_t  probs_out
);
    import softmax_pkg::*;

    logic          exp_valid;      // frontend -> divider
    exp_bundle_t   exp_bundle;
    logic          recip_valid;    // divider -> backend
    recip_bundle_t recip_bundle;

    softmax_frontend i_frontend (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .logits_in  (logits_in),
        .exp_valid  (exp_valid),
        .exp_bundle (exp_bundle)
    );

    reciprocal_divider i_divider (
        .clk          (clk),
        .rst_n        (rst_n),
        .exp_valid    (exp_valid),
        .exp_bundle   (exp_bundle),
        .recip_valid  (recip_valid),
        .recip_bundle (recip_bundle)
    );

    softmax_backend i_backend (
        .clk          (clk),
        .rst_n        (rst_n),
        .recip_valid  (recip_valid),
        .recip_bundle (recip_bundle),
        .valid_out    (valid_out),
        .probs_out    (probs_out)
    );

endmodule

//--- testbench/softmax_sva.sv
/*
 * assertions bound into softmax_top
 *   strobe latency, known strobes, probability range
 */
`timescale 1ns/10ps

module softmax_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   valid_in,
    input logic                   exp_valid,
    input logic                   recip_valid,
    input logic                   valid_out,
    input softmax_pkg::prob_vec_t probs_out
);
    import softmax_pkg::*;

    // output strobe is the input strobe delayed by the whole pipe
    assert property (@(posedge clk) disable iff (!rst_n)
        valid_in |-> ##pipe_latency valid_out)
        else $error("valid_out missing %0d cycles after valid_in", pipe_latency);

    assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> $past(valid_in, pipe_latency))   // no strobe out of nowhere
        else $error("valid_out without valid_in %0d cycles before", pipe_latency);

    assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid |-> ##4 recip_valid)   // s0, s1, s2, output register
        else $error("recip_valid missing 4 cycles after exp_valid");

    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({valid_in, exp_valid, recip_valid, valid_out}))
        else $error("strobe unknown out of reset");

    // no probability above 1.0
    for (genvar i = 0; i < vec_len; i++) begin : g_range
        assert property (@(posedge clk) disable iff (!rst_n)
            valid_out |-> (probs_out[i] <= one_q))
            else $error("probs_out[%0d] above one_q", i);
    end

endmodule

bind softmax_top softmax_sva i_sva (.*);

//--- testbench/softmax_tb.sv
/*
 * softmax testbench
 *   clock, reset, reference model, compare tasks
 *   directed tests, output monitor, watchdog
 */
`timescale 1ns/10ps

module softmax_tb;
    import softmax_pkg::*;

    localparam int clk_period    = 8;
    localparam int total_vectors = 59;                  // 1 + 2 + 2 + 40 + 14
    localparam int drain_limit   = pipe_latency + 20;

    logic       clk;
    logic       rst_n;
    logic       valid_in;
    logit_vec_t logits_in;
    logic       valid_out;
    prob_vec_t  probs_out;

    int         exp_table [exp_lut_depth];   // model table, real exp then rounding
    prob_vec_t  exp_q [$];                   // expected vectors in flight
    int         due_q [$];                   // cycle each result is due
    int         cycle_cnt = 0;
    int         out_cnt   = 0;
    int         check_cnt = 0;
    int         error_cnt = 0;
    int         vec_cnt   = 0;
    integer     seed;

    softmax_top i_softmax_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .logits_in (logits_in),
        .valid_out (valid_out),
        .probs_out (probs_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt++;   // read only off the rising edge

    // watchdog, all vectors plus pipe plus margin
    initial begin
        #((total_vectors + pipe_latency + 200) * clk_period);
        $display("timeout: pipeline results did not arrive in time");
        $display("test failed");
        $finish;
    end

    // ========================================
    // reference model and compare tasks
    // ========================================
    task automatic model_softmax(input logit_vec_t v, output prob_vec_t p);
        logit_t elem;
        int     x [vec_len];
        int     e [vec_len];
        int     mx;
        int     idx;
        int     sum;
        int     recip;
        for (int i = 0; i < vec_len; i++) begin
            elem = v[i];
            x[i] = elem;                                   // sign extends
        end
        mx = x[0];
        for (int i = 1; i < vec_len; i++) begin
            if (x[i] > mx) mx = x[i];
        end
        sum = 0;
        for (int i = 0; i < vec_len; i++) begin
            idx = (mx - x[i]) / 256;                       // quarter-unit steps
            if (idx > exp_lut_depth - 1) idx = exp_lut_depth - 1;
            e[i] = exp_table[idx];
            sum += e[i];
        end
        recip = recip_dividend / sum;                      // truncated
        for (int i = 0; i < vec_len; i++) begin
            p[i] = prob_t'((e[i] * recip) >> frac_bits);
        end
    endtask

    task automatic compare_prob(input prob_t expected, input prob_t actual, input int idx);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("[FAIL] probs_out[%0d] expected 0x%h actual 0x%h", idx, expected, actual);
        end
    endtask

    task automatic compare_valid(input logic expected, input logic actual, input string when_txt);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("[FAIL] valid_out expected 0x%h actual 0x%h %s",
                     expected, actual, when_txt);
        end
    endtask

    task automatic compare_count(input int actual, input int expected, input string what);
        check_cnt++;
        if (actual != expected) begin
            error_cnt++;
            $display("%s is wrong, expected %0d but saw %0d", what, expected, actual);
        end
    endtask

    // pops one expected vector per output strobe
    always @(negedge clk) begin : monitor
        prob_vec_t want;
        int        due;
        if (rst_n && valid_out) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
                error_cnt++;
                $display("valid_out high with no vector pending, cycle %0d", cycle_cnt);
            end else begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                compare_count(cycle_cnt, due, "arrival cycle");
                for (int i = 0; i < vec_len; i++) begin
                    compare_prob(want[i], probs_out[i], i);
                end
            end
        end
    end

    // ========================================
    // stimulus helpers
    // ========================================
    task automatic drive_vector(input logit_vec_t v);
        prob_vec_t p;
        model_softmax(v, p);
        @(posedge clk);
        #1;
        valid_in  = 1'b1;
        logits_in = v;
        exp_q.push_back(p);
        due_q.push_back(cycle_cnt + pipe_latency);   // sampled next edge, out 8 later
        vec_cnt++;
    endtask

    task automatic release_input();
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic make_random(output logit_vec_t v);
        for (int i = 0; i < vec_len; i++) begin
            v[i] = logit_t'($random(seed) % 8192);   // within +-8.0
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            error_cnt++;
            $display("%0d results never came out of the pipeline", exp_q.size());
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, error_cnt - errs_before);
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic uniform_test();
        int         errs;
        logit_vec_t v;
        errs = error_cnt;
        for (int i = 0; i < vec_len; i++) v[i] = 16'sd512;
        drive_vector(v);
        release_input();
        wait_drain();
        for (int i = 0; i < vec_len; i++) begin
            compare_prob(prob_t'(64), probs_out[i], i);   // 1024 * (2^20 / 16384) >> 10
        end
        report_test("uniform vector", errs);
    endtask

    task automatic dominant_test();
        int         errs;
        logit_vec_t v;
        errs = error_cnt;
        v    = '0;
        v[5] = 16'sd8192;                     // 8.0, others sit at index 32
        drive_vector(v);
        release_input();
        wait_drain();
        compare_prob(prob_t'(one_q), probs_out[5], 5);
        for (int i = 0; i < vec_len; i++) begin
            v[i] = logit_t'(8192 - 512 * i);  // indices 0, 2, .. 30
        end
        drive_vector(v);
        release_input();
        wait_drain();
        report_test("dominant element", errs);
    endtask

    task automatic clamp_test();
        int         errs;
        logit_vec_t v;
        errs = error_cnt;
        v[0] = 16'sd15360;                    // 15.0
        v[1] = -16'sd768;                     // exactly index 63
        for (int i = 2; i < vec_len; i++) begin
            v[i] = logit_t'(-16384 - 1024 * i);   // past the table end
        end
        drive_vector(v);
        for (int i = 0; i < vec_len; i++) v[i] = 16'sh8000;
        v[7] = 16'sd256;
        drive_vector(v);
        release_input();
        wait_drain();
        report_test("clamp to table end", errs);
    endtask

    task automatic streaming_test();
        int         errs;
        int         seen;
        logit_vec_t v;
        errs = error_cnt;
        seen = out_cnt;
        for (int n = 0; n < 40; n++) begin
            make_random(v);
            drive_vector(v);                  // back to back
        end
        release_input();
        wait_drain();
        compare_count(out_cnt - seen, 40, "streaming output count");
        report_test("streaming", errs);
    endtask

    task automatic reset_flush_test();
        int         errs;
        logit_vec_t v;
        errs = error_cnt;
        for (int n = 0; n < 10; n++) begin
            make_random(v);
            drive_vector(v);
        end
        @(posedge clk);
        #1;
        rst_n    = 1'b0;                      // third result on the output, rest inside
        valid_in = 1'b0;
        exp_q.delete();
        due_q.delete();
        @(negedge clk);
        compare_valid(1'b0, valid_out, "while reset asserted");
        for (int i = 0; i < vec_len; i++) compare_prob('0, probs_out[i], i);
        repeat (pipe_latency + 2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            compare_valid(1'b0, valid_out, "after reset with no new input");
        end
        for (int n = 0; n < 4; n++) begin
            make_random(v);
            drive_vector(v);
        end
        release_input();
        wait_drain();
        report_test("reset during traffic", errs);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        seed      = 69094;
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        logits_in = '0;
        for (int k = 0; k < exp_lut_depth; k++) begin
            exp_table[k] = $rtoi(one_q * $exp(-k / 4.0) + 0.5);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        uniform_test();
        dominant_test();
        clamp_test();
        streaming_test();
        reset_flush_test();
        $display("summary: %0d vectors, %0d outputs, %0d checks, %0d errors",
                 vec_cnt, out_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
